//--- rtl/uartPkg.sv
/*
  Serial-side types and constants of the UART.
  Imported by the baud generator, the transmitter, the receiver and the register block.
*/
`default_nettype none

package uartPkg;

  // Width of the baud divider reload value
  localparam int DivisorWidth = 16;

  // Oversample ticks in one bit time
  localparam int OversampleRate = 7;

  typedef logic [7:0] uartByteT;
  typedef logic [DivisorWidth-1:0] divisorT;

  // One received frame as handed to the register block
  typedef struct packed {
    uartByteT data;
    logic     framingError;
  } rxFrameT;

endpackage

`default_nettype wire

//--- rtl/axiLitePkg.sv
/*
  AXI4-Lite bus types, response codes and the UART register map.
  The master side drives axiLiteReqT and the slave answers with axiLiteRespT.
*/
`default_nettype none

package axiLitePkg;

  typedef logic [3:0] axiAddrT;
  typedef logic [31:0] axiDataT;
  typedef logic [1:0] axiRespT;

  localparam axiRespT RespOkay = 2'd0;
  localparam axiRespT RespSlvErr = 2'd2;

  // Register offsets, all word aligned
  localparam axiAddrT AddrData = 4'h0;
  localparam axiAddrT AddrStatus = 4'h4;
  localparam axiAddrT AddrDivisor = 4'h8;

  // Bit positions inside the STATUS word
  localparam int StatusTxReady = 0;
  localparam int StatusRxValid = 1;
  localparam int StatusOverrun = 2;
  localparam int StatusFramingErr = 3;

  // Everything the master drives
  typedef struct packed {
    axiAddrT awAddr;
    logic    awValid;
    axiDataT wData;
    logic    wValid;
    logic    bReady;
    axiAddrT arAddr;
    logic    arValid;
    logic    rReady;
  } axiLiteReqT;

  // Everything the slave drives
  typedef struct packed {
    logic    awReady;
    logic    wReady;
    axiRespT bResp;
    logic    bValid;
    logic    arReady;
    axiDataT rData;
    axiRespT rResp;
    logic    rValid;
  } axiLiteRespT;

endpackage

`default_nettype wire

//--- rtl/baudGen.sv
/*
  Programmable baud divider.
  sampleTick pulses once every divisor + 1 cycles and bitTick on every seventh sampleTick.
*/
`timescale 1ns/10ps
`default_nettype none

module baudGen (
  input  logic             clk,
  input  logic             rstN,
  input  uartPkg::divisorT divisor,
  output logic             sampleTick,
  output logic             bitTick
);
  import uartPkg::*;

  localparam int SampleCntWidth = $clog2(OversampleRate);

  divisorT divCnt;
  logic [SampleCntWidth-1:0] sampleCnt;

  // The oversample tick fires when the down-counter has run out
  assign sampleTick = (divCnt == '0);

  // Every seventh oversample tick is also a bit tick
  assign bitTick = sampleTick && (sampleCnt == SampleCntWidth'(OversampleRate - 1));

  // A new divisor value is only picked up here at reload time
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      divCnt <= '0;
    end else if (sampleTick) begin
      divCnt <= divisor;
    end else begin
      divCnt <= divCnt - 1'b1;
    end
  end

  // Modulo-7 count of oversample ticks
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sampleCnt <= '0;
    end else if (bitTick) begin
      sampleCnt <= '0;
    end else if (sampleTick) begin
      sampleCnt <= sampleCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uartTx.sv
/*
  8N1 serial transmitter driven by a one-cycle start pulse.
  The frame goes out on the bit ticks that follow the pulse.
*/
`timescale 1ns/10ps
`default_nettype none

module uartTx (
  input  logic              clk,
  input  logic              rstN,
  input  logic              bitTick,
  input  uartPkg::uartByteT txData,
  input  logic              txStart,
  output logic              txReady,
  output logic              tx
);

  // Start bit, data and stop bit, all stored inverted
  logic [9:0] txShift;
  // Bits still to be shifted after the start bit
  logic [3:0] bitsLeft;
  // Frame is loaded and waits for the next bit tick
  logic pending;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      txShift <= '0;
      bitsLeft <= '0;
      pending <= 1'b0;
    end else if (txStart) begin
      // Stop bit inverted to 0, data inverted, start bit inverted to 1
      txShift <= {1'b0, ~txData, 1'b1};
      pending <= 1'b1;
    end else if (pending && bitTick) begin
      // Start bit now appears on the line
      pending <= 1'b0;
      bitsLeft <= 4'd9;
    end else if ((bitsLeft != '0) && bitTick) begin
      txShift <= txShift >> 1;
      bitsLeft <= bitsLeft - 1'b1;
    end
  end

  // An all-zero register reads as idle high once every bit has left
  // While a frame is pending the line is still held idle
  assign tx = ~txShift[0] | pending;

  // Ready already during the stop bit so frames can go back to back
  assign txReady = (bitsLeft == '0) && !pending;

endmodule

`default_nettype wire

//--- rtl/uartRx.sv
/*
  8N1 serial receiver with a two-flop input synchronizer.
  It oversamples on sampleTick, samples each bit at its centre and checks the stop bit.
*/
`timescale 1ns/10ps
`default_nettype none

module uartRx (
  input  logic             clk,
  input  logic             rstN,
  input  logic             sampleTick,
  input  logic             rx,
  output uartPkg::rxFrameT rxFrame,
  output logic             rxDone
);
  import uartPkg::*;

  localparam int TickWidth = $clog2(OversampleRate);

  logic [1:0] rxSyncQ;
  logic rxSync;
  logic busy;
  logic [TickWidth-1:0] tickCnt;
  // Index of the next bit to sample, 0 is the start bit and 9 the stop bit
  logic [3:0] bitIdx;
  uartByteT dataShift;

  assign rxSync = rxSyncQ[1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxSyncQ <= 2'b11;
      busy <= 1'b0;
      tickCnt <= '0;
      bitIdx <= '0;
      rxDone <= 1'b0;
    end else begin
      rxSyncQ <= {rxSyncQ[0], rx};
      rxDone <= 1'b0;
      if (sampleTick) begin
        if (!busy) begin
          if (!rxSync) begin
            // Low line seen, the start bit centre is three ticks away
            busy <= 1'b1;
            bitIdx <= '0;
            tickCnt <= TickWidth'(OversampleRate / 2 - 1);
          end
        end else if (tickCnt != '0) begin
          tickCnt <= tickCnt - 1'b1;
        end else begin
          // At a bit centre, the next one follows seven ticks later
          tickCnt <= TickWidth'(OversampleRate - 1);
          bitIdx <= bitIdx + 1'b1;
          if (bitIdx == 4'd0 && rxSync) begin
            // Line went high again so it was only a glitch
            busy <= 1'b0;
          end else if (bitIdx == 4'd9) begin
            busy <= 1'b0;
            rxDone <= 1'b1;
          end
        end
      end
    end
  end

  // Data and frame registers carry payload only
  always_ff @(posedge clk) begin
    if (sampleTick && busy && tickCnt == '0) begin
      if (bitIdx >= 4'd1 && bitIdx <= 4'd8) begin
        // LSB arrives first so bits enter at the top
        dataShift <= {rxSync, dataShift[7:1]};
      end
      if (bitIdx == 4'd9) begin
        rxFrame.data <= dataShift;
        rxFrame.framingError <= ~rxSync;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/uartRegs.sv
/*
  AXI4-Lite slave holding the DATA, STATUS and DIVISOR registers of the UART.
  It starts the transmitter, collects received bytes and keeps the sticky error flags.
*/
`timescale 1ns/10ps
`default_nettype none

module uartRegs #(
  parameter uartPkg::divisorT ResetDivisor = 16'd7
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  axiLitePkg::axiLiteReqT  busReq,
  output axiLitePkg::axiLiteRespT busResp,
  output uartPkg::uartByteT       txData,
  output logic                    txStart,
  input  logic                    txReady,
  input  uartPkg::rxFrameT        rxFrame,
  input  logic                    rxDone,
  output uartPkg::divisorT        divisor
);
  import uartPkg::*;
  import axiLitePkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stWriteResp,
    stReadData
  } busStateT;

  busStateT state;
  logic writeAccept;
  logic readAccept;
  logic writeMapped;
  uartByteT rxData;
  logic rxValid;
  logic overrun;
  logic framingErr;
  axiRespT bResp;
  axiRespT rResp;
  axiRespT readResp;
  axiDataT rData;
  axiDataT readWord;
  axiDataT statusWord;

  // Requests are only taken in idle, and a write beats a read in the same cycle
  assign writeAccept = (state == stIdle) && busReq.awValid && busReq.wValid;
  assign readAccept = (state == stIdle) && busReq.arValid && !writeAccept;
  assign writeMapped = busReq.awAddr inside {AddrData, AddrStatus, AddrDivisor};

  // A DATA write while the transmitter is busy is silently dropped
  assign txStart = writeAccept && (busReq.awAddr == AddrData) && txReady;
  assign txData = busReq.wData[$bits(uartByteT)-1:0];

  always_comb begin
    busResp.awReady = writeAccept;
    busResp.wReady = writeAccept;
    busResp.bResp = bResp;
    busResp.bValid = (state == stWriteResp);
    busResp.arReady = readAccept;
    busResp.rData = rData;
    busResp.rResp = rResp;
    busResp.rValid = (state == stReadData);
  end

  always_comb begin
    statusWord = '0;
    statusWord[StatusTxReady] = txReady;
    statusWord[StatusRxValid] = rxValid;
    statusWord[StatusOverrun] = overrun;
    statusWord[StatusFramingErr] = framingErr;
  end

  // Read decode, unmapped offsets return zero with an error response
  always_comb begin
    readWord = '0;
    readResp = RespOkay;
    case (busReq.arAddr)
      AddrData:    readWord = axiDataT'(rxData);
      AddrStatus:  readWord = statusWord;
      AddrDivisor: readWord = axiDataT'(divisor);
      default:     readResp = RespSlvErr;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
      rxValid <= 1'b0;
      overrun <= 1'b0;
      framingErr <= 1'b0;
      divisor <= ResetDivisor;
    end else begin
      case (state)
        stIdle: begin
          if (writeAccept) begin
            state <= stWriteResp;
          end else if (readAccept) begin
            state <= stReadData;
          end
        end
        stWriteResp: begin
          if (busReq.bReady) begin
            state <= stIdle;
          end
        end
        stReadData: begin
          if (busReq.rReady) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase

      if (writeAccept && busReq.awAddr == AddrDivisor) begin
        divisor <= busReq.wData[DivisorWidth-1:0];
      end
      // Error flags clear on a written 1
      if (writeAccept && busReq.awAddr == AddrStatus) begin
        if (busReq.wData[StatusOverrun]) begin
          overrun <= 1'b0;
        end
        if (busReq.wData[StatusFramingErr]) begin
          framingErr <= 1'b0;
        end
      end
      if (readAccept && busReq.arAddr == AddrData) begin
        rxValid <= 1'b0;
      end
      // A new byte takes priority over any clear in the same cycle
      if (rxDone) begin
        rxValid <= 1'b1;
        if (rxValid) begin
          overrun <= 1'b1;
        end
        if (rxFrame.framingError) begin
          framingErr <= 1'b1;
        end
      end
    end
  end

  // Received byte and response payloads
  always_ff @(posedge clk) begin
    if (rxDone) begin
      rxData <= rxFrame.data;
    end
    if (writeAccept) begin
      bResp <= writeMapped ? RespOkay : RespSlvErr;
    end
    if (readAccept) begin
      rData <= readWord;
      rResp <= readResp;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uartTop.sv
/*
  UART peripheral with an AXI4-Lite slave port and an 8N1 serial line.
  ResetDivisor sets the baud divider after reset.
*/
`timescale 1ns/10ps
`default_nettype none

module uartTop #(
  parameter uartPkg::divisorT ResetDivisor = 16'd7
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  axiLitePkg::axiLiteReqT  busReq,
  output axiLitePkg::axiLiteRespT busResp,
  input  logic                    rx,
  output logic                    tx
);
  import uartPkg::*;

  uartByteT txData;
  logic txStart;
  logic txReady;
  rxFrameT rxFrame;
  logic rxDone;
  divisorT divisor;
  logic sampleTick;
  logic bitTick;

  // Register block steers the serial logic
  uartRegs #(
    .ResetDivisor(ResetDivisor)
  ) regs_i (
    .clk(clk),
    .rstN(rstN),
    .busReq(busReq),
    .busResp(busResp),
    .txData(txData),
    .txStart(txStart),
    .txReady(txReady),
    .rxFrame(rxFrame),
    .rxDone(rxDone),
    .divisor(divisor)
  );

  baudGen baud_i (
    .clk(clk),
    .rstN(rstN),
    .divisor(divisor),
    .sampleTick(sampleTick),
    .bitTick(bitTick)
  );

  uartTx tx_i (
    .clk(clk),
    .rstN(rstN),
    .bitTick(bitTick),
    .txData(txData),
    .txStart(txStart),
    .txReady(txReady),
    .tx(tx)
  );

  // The receiver runs off the oversample tick only
  uartRx rx_i (
    .clk(clk),
    .rstN(rstN),
    .sampleTick(sampleTick),
    .rx(rx),
    .rxFrame(rxFrame),
    .rxDone(rxDone)
  );

endmodule

`default_nettype wire

//--- tests/clockGen.sv
/*
  Testbench clock and reset source.
  Makes an 8 ns clock and holds rstN low for the first ResetCycles cycles.
*/
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
  parameter int ResetCycles = 10
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    // Release on a falling edge, away from the active clock edge
    @(negedge clk);
    rstN = 1'b1;
  end

  always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- tests/uartTb.sv
/*
  Table-driven testbench of the UART peripheral.
  Drives the AXI4-Lite port and the rx line on falling edges and decodes frames on tx.
*/
`timescale 1ns/10ps
`default_nettype none

module uartTb;
  import uartPkg::*;
  import axiLitePkg::*;

  localparam divisorT ResetDivisor = 16'd1;
  localparam int BitCycles = OversampleRate * (ResetDivisor + 1);
  localparam int TableLen = 6;
  localparam int MarginCycles = 6000;
  // Every table byte goes out once and comes in once with ten bits per frame
  localparam int MaxCycles = TableLen * 2 * 10 * BitCycles + MarginCycles;

  typedef struct packed {
    uartByteT data;
    axiDataT  statusFull;
    axiDataT  statusEmpty;
  } tableEntryT;

  logic clk;
  logic rstN;
  axiLiteReqT busReq;
  axiLiteRespT busResp;
  logic rx;
  logic tx;
  tableEntryT testTable [TableLen];
  integer seed;
  int errorCount = 0;
  int errorsAtStart = 0;
  int testsPassed = 0;
  int testsFailed = 0;
  int cycleCount = 0;

  clockGen #(.ResetCycles(10)) clock_i (.clk(clk), .rstN(rstN));

  uartTop #(
    .ResetDivisor(ResetDivisor)
  ) dut_i (
    .clk(clk),
    .rstN(rstN),
    .busReq(busReq),
    .busResp(busResp),
    .rx(rx),
    .tx(tx)
  );

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
      $display("Test failed");
      $finish;
    end
  end

  // Builds a STATUS word from the register map bit positions
  function automatic axiDataT expectStatus(input logic txRdy, input logic rxVal,
                                           input logic ovr, input logic fe);
    axiDataT word;
    word = '0;
    word[StatusTxReady] = txRdy;
    word[StatusRxValid] = rxVal;
    word[StatusOverrun] = ovr;
    word[StatusFramingErr] = fe;
    return word;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  // One summary line per finished test
  task automatic endTest(input string name);
    if (errorCount == errorsAtStart) begin
      testsPassed++;
      $display("ok    %s", name);
    end else begin
      testsFailed++;
      $display("error %s (%0d mismatches)", name, errorCount - errorsAtStart);
    end
    errorsAtStart = errorCount;
  endtask

  task automatic fillTable();
    for (int i = 0; i < TableLen; i++) begin
      case (i)
        0: testTable[i].data = 8'h55;
        1: testTable[i].data = 8'h00;
        2: testTable[i].data = 8'hFF;
        3: testTable[i].data = 8'hA3;
        default: testTable[i].data = uartByteT'($random(seed));
      endcase
      testTable[i].statusFull = expectStatus(1'b1, 1'b1, 1'b0, 1'b0);
      testTable[i].statusEmpty = expectStatus(1'b1, 1'b0, 1'b0, 1'b0);
    end
  endtask

  // Address and data go out together
  // Ready is checked just after the falling edge
  task automatic busWrite(input axiAddrT addr, input axiDataT data, output axiRespT resp);
    @(negedge clk);
    busReq.awAddr = addr;
    busReq.awValid = 1'b1;
    busReq.wData = data;
    busReq.wValid = 1'b1;
    busReq.bReady = 1'b1;
    #1;
    while (!busResp.awReady) begin
      @(negedge clk);
      #1;
    end
    checkValue("wReady", busResp.wReady, 1'b1);
    @(negedge clk);
    busReq.awValid = 1'b0;
    busReq.wValid = 1'b0;
    while (!busResp.bValid) begin
      @(negedge clk);
    end
    resp = busResp.bResp;
    @(negedge clk);
    busReq.bReady = 1'b0;
  endtask

  task automatic busRead(input axiAddrT addr, output axiDataT data, output axiRespT resp);
    @(negedge clk);
    busReq.arAddr = addr;
    busReq.arValid = 1'b1;
    busReq.rReady = 1'b1;
    #1;
    while (!busResp.arReady) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    busReq.arValid = 1'b0;
    while (!busResp.rValid) begin
      @(negedge clk);
    end
    data = busResp.rData;
    resp = busResp.rResp;
    @(negedge clk);
    busReq.rReady = 1'b0;
  endtask

  task automatic waitStatusBit(input int index);
    axiDataT word;
    axiRespT resp;
    word = '0;
    while (!word[index]) begin
      busRead(AddrStatus, word, resp);
    end
  endtask

  // Drives one 8N1 frame on rx
  // A low stop bit ends just past its centre
  task automatic sendFrame(input uartByteT data, input logic stopBit, input int bitCycles);
    logic [9:0] bits;
    bits = {stopBit, data, 1'b0};
    @(negedge clk);
    for (int i = 0; i < 9; i++) begin
      rx = bits[i];
      repeat (bitCycles) @(negedge clk);
    end
    rx = stopBit;
    if (stopBit) begin
      repeat (bitCycles) @(negedge clk);
    end else begin
      repeat (bitCycles / 2 + 2) @(negedge clk);
    end
    rx = 1'b1;
    repeat (2 * bitCycles) @(negedge clk);
  endtask

  // Waits for a start edge on tx and samples each bit at its centre
  task automatic captureFrame(input int bitCycles, output logic startBit,
                              output uartByteT data, output logic stopBit);
    @(negedge clk);
    while (tx !== 1'b0) begin
      @(negedge clk);
    end
    repeat (bitCycles / 2) @(negedge clk);
    startBit = tx;
    for (int i = 0; i < 8; i++) begin
      repeat (bitCycles) @(negedge clk);
      data[i] = tx;
    end
    repeat (bitCycles) @(negedge clk);
    stopBit = tx;
  endtask

  task automatic transmitByte(input uartByteT data, input int bitCycles);
    logic startBit;
    logic stopBit;
    uartByteT seen;
    axiRespT resp;
    waitStatusBit(StatusTxReady);
    fork
      captureFrame(bitCycles, startBit, seen, stopBit);
      busWrite(AddrData, axiDataT'(data), resp);
    join
    checkValue("bResp", resp, RespOkay);
    checkValue("tx start bit", startBit, 1'b0);
    checkValue("tx data", seen, data);
    checkValue("tx stop bit", stopBit, 1'b1);
  endtask

  task automatic receiveByte(input uartByteT data, input axiDataT expFull,
                             input axiDataT expEmpty, input int bitCycles);
    axiDataT word;
    axiRespT resp;
    sendFrame(data, 1'b1, bitCycles);
    waitStatusBit(StatusRxValid);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS with byte", word, expFull);
    busRead(AddrData, word, resp);
    checkValue("DATA", word, axiDataT'(data));
    checkValue("rResp", resp, RespOkay);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS after DATA read", word, expEmpty);
  endtask

  initial begin
    axiDataT word;
    axiRespT resp;
    logic startBit;
    logic stopBit;
    uartByteT seen;
    busReq = '0;
    rx = 1'b1;
    seed = 32'h8095;
    fillTable();
    wait (rstN === 1'b1);
    @(negedge clk);

    checkValue("tx", tx, 1'b1);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS", word, expectStatus(1'b1, 1'b0, 1'b0, 1'b0));
    checkValue("rResp", resp, RespOkay);
    busRead(AddrDivisor, word, resp);
    checkValue("DIVISOR", word, 32'd1);
    endTest("reset values");

    for (int i = 0; i < TableLen; i++) begin
      transmitByte(testTable[i].data, BitCycles);
      endTest($sformatf("transmit 0x%02h", testTable[i].data));
    end
    for (int i = 0; i < TableLen; i++) begin
      receiveByte(testTable[i].data, testTable[i].statusFull, testTable[i].statusEmpty,
                  BitCycles);
      endTest($sformatf("receive 0x%02h", testTable[i].data));
    end

    // Second byte lands on an unread first one
    sendFrame(8'h3C, 1'b1, BitCycles);
    sendFrame(8'hC3, 1'b1, BitCycles);
    waitStatusBit(StatusRxValid);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS overrun", word, expectStatus(1'b1, 1'b1, 1'b1, 1'b0));
    busRead(AddrData, word, resp);
    checkValue("DATA after overrun", word, 32'hC3);
    endTest("overrun");

    // Overrun is still pending from the frames above
    sendFrame(8'h5A, 1'b0, BitCycles);
    waitStatusBit(StatusRxValid);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS framing", word, expectStatus(1'b1, 1'b1, 1'b1, 1'b1));
    endTest("framing error");

    busWrite(AddrStatus, expectStatus(1'b0, 1'b0, 1'b1, 1'b1), resp);
    checkValue("bResp", resp, RespOkay);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS after clear", word, expectStatus(1'b1, 1'b1, 1'b0, 1'b0));
    busRead(AddrData, word, resp);
    checkValue("DATA of bad frame", word, 32'h5A);
    busRead(AddrStatus, word, resp);
    checkValue("STATUS empty", word, expectStatus(1'b1, 1'b0, 1'b0, 1'b0));
    endTest("flag clear");

    busRead(4'hC, word, resp);
    checkValue("rResp unmapped", resp, RespSlvErr);
    checkValue("rData unmapped", word, 32'd0);
    busWrite(4'hC, 32'hFFFF_FFFF, resp);
    checkValue("bResp unmapped", resp, RespSlvErr);
    endTest("unmapped address");

    // The second byte arrives while the first is still pending
    waitStatusBit(StatusTxReady);
    fork
      captureFrame(BitCycles, startBit, seen, stopBit);
      begin
        busWrite(AddrData, 32'h96, resp);
        busWrite(AddrData, 32'h69, resp);
      end
    join
    checkValue("bResp busy write", resp, RespOkay);
    checkValue("tx start bit", startBit, 1'b0);
    checkValue("tx data", seen, 8'h96);
    checkValue("tx stop bit", stopBit, 1'b1);
    endTest("write while busy");

    busWrite(AddrDivisor, 32'd3, resp);
    busRead(AddrDivisor, word, resp);
    checkValue("DIVISOR", word, 32'd3);
    transmitByte(8'hB7, OversampleRate * 4);
    receiveByte(8'h4E, expectStatus(1'b1, 1'b1, 1'b0, 1'b0),
                expectStatus(1'b1, 1'b0, 1'b0, 1'b0), OversampleRate * 4);
    endTest("divisor 3");

    $display("%0d tests ok, %0d tests with errors, %0d mismatches in total",
             testsPassed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/uartPkg.sv
rtl/axiLitePkg.sv
rtl/baudGen.sv
rtl/uartTx.sv
rtl/uartRx.sv
rtl/uartRegs.sv
rtl/uartTop.sv
tests/clockGen.sv
tests/uartTb.sv
